// ==== logic/core_params.svh ====
// core-wide width, reset and latency constants.
// shared by the packages and the pipeline stages.

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and pc width.
`define CORE_XLEN 64

// register index width, 32 integer registers.
`define CORE_REG_AW 5

// first fetch address after reset.
`define CORE_RESET_PC 64'h0

// cycles a MUL spends in execute, at least 2.
`define CORE_MUL_CYCLES 4

`endif

// ==== logic/execute_stage.sv ====
// second stage: alu, multi-cycle multiplier, branch resolution,
// redirect, register writeback and retire report.

`timescale 1ns/1ps
`include "core_params.svh"

module execute_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  idex_t   ex_bundle,
    output logic    ex_ready,
    output logic    redirect_valid,
    output pc_t     redirect_pc,
    output wb_t     wb,
    output retire_t retire
);

    typedef enum logic {
        MUL_IDLE,
        MUL_BUSY
    } mul_state_e;

    localparam int CNT_W = $clog2(`CORE_MUL_CYCLES + 1);

    mul_state_e       mul_state;
    logic [CNT_W-1:0] mul_cnt;
    xlen_t            mul_prod;
    xlen_t            opb;
    xlen_t            alu_res;
    xlen_t            result;
    logic             is_mul;
    logic             mul_done;
    logic             done;
    logic             taken;

    assign opb = ex_bundle.use_imm ? ex_bundle.imm : ex_bundle.op2;

    always_comb begin
        case (ex_bundle.alu_op)
            ALU_ADD:    alu_res = ex_bundle.op1 + opb;
            ALU_SUB:    alu_res = ex_bundle.op1 - opb;
            ALU_AND:    alu_res = ex_bundle.op1 & opb;
            ALU_OR:     alu_res = ex_bundle.op1 | opb;
            ALU_XOR:    alu_res = ex_bundle.op1 ^ opb;
            ALU_SLT:    alu_res = xlen_t'($signed(ex_bundle.op1) < $signed(opb));
            ALU_PASS_B: alu_res = opb;
            default:    alu_res = mul_prod;
        endcase
    end

    assign is_mul   = ex_bundle.valid && ex_bundle.alu_op == ALU_MUL;
    assign mul_done = (mul_state == MUL_BUSY) && (mul_cnt == '0);
    assign ex_ready = !is_mul || mul_done;
    assign done     = ex_bundle.valid && ex_ready;

    // first cycle starts the count, the last one retires.
    always_ff @(posedge clk) begin
        if (reset) begin
            mul_state <= MUL_IDLE;
            mul_cnt   <= '0;
        end else begin
            case (mul_state)
                MUL_IDLE: begin
                    if (is_mul) begin
                        mul_state <= MUL_BUSY;
                        mul_cnt   <= CNT_W'(`CORE_MUL_CYCLES - 2);
                    end
                end
                default: begin
                    if (mul_cnt == '0) begin
                        mul_state <= MUL_IDLE;
                    end else begin
                        mul_cnt <= mul_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // product taken once on entry, low half only.
    always_ff @(posedge clk) begin
        if (mul_state == MUL_IDLE && is_mul) begin
            mul_prod <= ex_bundle.op1 * ex_bundle.op2;
        end
    end

    always_comb begin
        case (ex_bundle.branch)
            BR_BEQ:  taken = (ex_bundle.op1 == ex_bundle.op2);
            BR_BNE:  taken = (ex_bundle.op1 != ex_bundle.op2);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_valid = ex_bundle.valid && taken;
    assign redirect_pc    = ex_bundle.pc + ex_bundle.imm;

    // link value for jal; x0 always reports zero.
    assign result = (ex_bundle.rd_addr == '0) ? '0 :
                    (ex_bundle.branch == BR_JAL) ? ex_bundle.pc + pc_t'(4) : alu_res;

    assign wb.ena  = done && ex_bundle.rd_ena;
    assign wb.addr = ex_bundle.rd_addr;
    assign wb.data = result;

    assign retire.valid   = done;
    assign retire.pc      = ex_bundle.pc;
    assign retire.rd_ena  = ex_bundle.rd_ena;
    assign retire.rd_addr = ex_bundle.rd_addr;
    assign retire.value   = result;

    // a busy multiplier always sees its own held bundle.
    a_mul_cnt_range: assert property (@(posedge clk) disable iff (reset)
        mul_state == MUL_BUSY |-> is_mul && mul_cnt <= CNT_W'(`CORE_MUL_CYCLES));

endmodule

// ==== logic/fetch_decode.sv ====
// first stage: pc register, instruction fetch, decoder,
// operand read and bypass from the writeback of execute.

`timescale 1ns/1ps
`include "core_params.svh"

module fetch_decode import isa_pkg::*; import pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output pc_t       imem_addr,
    input  inst_t     imem_data,
    input  logic      ex_ready,
    input  logic      redirect_valid,
    input  pc_t       redirect_pc,
    input  wb_t       wb,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  xlen_t     rs1_data,
    input  xlen_t     rs2_data,
    output idex_t     id_bundle
);

    typedef enum logic {
        FD_BOOT,
        FD_RUN
    } fd_state_e;

    fd_state_e state;
    pc_t       pc;
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    xlen_t     imm_i;
    xlen_t     imm_u;
    xlen_t     imm_b;
    xlen_t     imm_j;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    logic      legal;

    // first cycle after reset only addresses memory, no decode.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FD_BOOT;
            pc    <= `CORE_RESET_PC;
        end else begin
            state <= FD_RUN;
            if (state == FD_RUN && ex_ready) begin
                if (redirect_valid) begin
                    pc <= redirect_pc;
                end else begin
                    pc <= pc + pc_t'(4);
                end
            end
        end
    end

    assign imem_addr = pc;

    assign opcode   = imem_data[6:0];
    assign funct3   = imem_data[14:12];
    assign funct7   = imem_data[31:25];
    assign rs1_addr = imem_data[19:15];
    assign rs2_addr = imem_data[24:20];

    assign imm_i = {{52{imem_data[31]}}, imem_data[31:20]};
    assign imm_u = {{32{imem_data[31]}}, imem_data[31:12], 12'b0};
    assign imm_b = {{51{imem_data[31]}}, imem_data[31], imem_data[7],
                    imem_data[30:25], imem_data[11:8], 1'b0};
    assign imm_j = {{43{imem_data[31]}}, imem_data[31], imem_data[19:12],
                    imem_data[20], imem_data[30:21], 1'b0};

    // the write in execute lands at the end of this cycle, so forward it.
    assign rs1_val = (wb.ena && wb.addr != '0 && wb.addr == rs1_addr) ? wb.data : rs1_data;
    assign rs2_val = (wb.ena && wb.addr != '0 && wb.addr == rs2_addr) ? wb.data : rs2_data;

    always_comb begin
        id_bundle         = '0;
        id_bundle.pc      = pc;
        id_bundle.op1     = rs1_val;
        id_bundle.op2     = rs2_val;
        id_bundle.rd_addr = imem_data[11:7];
        id_bundle.alu_op  = ALU_ADD;
        id_bundle.branch  = BR_NONE;
        legal             = 1'b1;
        case (opcode)
            OPC_OP_IMM: begin
                id_bundle.imm     = imm_i;
                id_bundle.use_imm = 1'b1;
                id_bundle.rd_ena  = 1'b1;
                legal             = (funct3 == F3_ADD_SUB);
            end
            OPC_OP: begin
                id_bundle.rd_ena = 1'b1;
                if (funct7 == F7_MULDIV && funct3 == F3_ADD_SUB) begin
                    id_bundle.alu_op = ALU_MUL;
                end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
                    id_bundle.alu_op = ALU_SUB;
                end else if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: id_bundle.alu_op = ALU_ADD;
                        F3_SLT:     id_bundle.alu_op = ALU_SLT;
                        F3_XOR:     id_bundle.alu_op = ALU_XOR;
                        F3_OR:      id_bundle.alu_op = ALU_OR;
                        F3_AND:     id_bundle.alu_op = ALU_AND;
                        default:    legal = 1'b0;
                    endcase
                end else begin
                    legal = 1'b0;
                end
            end
            OPC_LUI: begin
                id_bundle.imm     = imm_u;
                id_bundle.use_imm = 1'b1;
                id_bundle.alu_op  = ALU_PASS_B;
                id_bundle.rd_ena  = 1'b1;
            end
            OPC_BRANCH: begin
                id_bundle.imm = imm_b;
                if (funct3 == F3_BEQ) begin
                    id_bundle.branch = BR_BEQ;
                end else if (funct3 == F3_BNE) begin
                    id_bundle.branch = BR_BNE;
                end else begin
                    legal = 1'b0;
                end
            end
            OPC_JAL: begin
                id_bundle.imm    = imm_j;
                id_bundle.branch = BR_JAL;
                id_bundle.rd_ena = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        // anything outside the subset becomes a bubble.
        id_bundle.valid = legal && (state == FD_RUN);
    end

endmodule

// ==== logic/idex_reg.sv ====
// decode to execute pipeline register with hold, flush and load.

`timescale 1ns/1ps

module idex_reg import isa_pkg::*; import pipe_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  ex_ready,
    input  logic  redirect_valid,
    input  idex_t id_bundle,
    output idex_t ex_bundle
);

    // cleared bundle, valid low.
    localparam idex_t BUBBLE = '0;

    // hold wins over flush.
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_bundle <= BUBBLE;
        end else if (!ex_ready) begin
            ex_bundle <= ex_bundle;
        end else if (redirect_valid) begin
            ex_bundle <= BUBBLE;
        end else begin
            ex_bundle <= id_bundle;
        end
    end

    // a stall comes only from a live mul and never coincides with a flush.
    a_hold_live: assert property (@(posedge clk) disable iff (reset)
        !ex_ready |-> ex_bundle.valid && ex_bundle.alu_op == ALU_MUL && !redirect_valid);

endmodule

// ==== logic/isa_pkg.sv ====
// instruction-set types: data, pc and instruction words, opcode and funct fields,
// alu operation and branch kind enums.

`include "core_params.svh"

package isa_pkg;

    typedef logic [`CORE_XLEN-1:0]   xlen_t;
    typedef logic [`CORE_XLEN-1:0]   pc_t;
    typedef logic [31:0]             inst_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_SUB    = 7'b0100000;
    localparam funct7_t F7_MULDIV = 7'b0000001;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B,
        ALU_MUL
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } branch_e;

endpackage

// ==== logic/pipe_pkg.sv ====
// pipeline bundles: decoded instruction, register write and retire report.

package pipe_pkg;

    import isa_pkg::*;

    // decoded bundle carried from decode into execute.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        xlen_t     op1;
        xlen_t     op2;
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        branch_e   branch;
        logic      rd_ena;
        reg_addr_t rd_addr;
    } idex_t;

    typedef struct packed {
        logic      ena;
        reg_addr_t addr;
        xlen_t     data;
    } wb_t;

    // one entry per completed instruction, in program order.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        logic      rd_ena;
        reg_addr_t rd_addr;
        xlen_t     value;
    } retire_t;

endpackage

// ==== logic/reg_file.sv ====
// integer register file, two asynchronous reads and one synchronous write.

`timescale 1ns/1ps

module reg_file import isa_pkg::*; import pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  wb_t       wb
);

    localparam int NREGS = 1 << $bits(reg_addr_t);

    xlen_t regs [NREGS];

    // x0 is never written.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.ena && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // writes aimed at x0 carry zero, matching the retire report.
    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        (wb.ena && wb.addr == '0) |-> wb.data == '0);

endmodule

// ==== logic/rv_core.sv ====
// two-stage rv64 integer core top level.
// decode, id/ex register, execute and register file.

`timescale 1ns/1ps

module rv_core import isa_pkg::*; import pipe_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output pc_t     imem_addr,
    input  inst_t   imem_data,
    output retire_t retire
);

    logic      ex_ready;
    logic      redirect_valid;
    pc_t       redirect_pc;
    wb_t       wb;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    idex_t     id_bundle;
    idex_t     ex_bundle;

    fetch_decode u_fetch_decode (
        .clk            (clk),
        .reset          (reset),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .ex_ready       (ex_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb             (wb),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .id_bundle      (id_bundle)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    idex_reg u_idex_reg (
        .clk            (clk),
        .reset          (reset),
        .ex_ready       (ex_ready),
        .redirect_valid (redirect_valid),
        .id_bundle      (id_bundle),
        .ex_bundle      (ex_bundle)
    );

    execute_stage u_execute_stage (
        .clk            (clk),
        .reset          (reset),
        .ex_bundle      (ex_bundle),
        .ex_ready       (ex_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb             (wb),
        .retire         (retire)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the core testbench with verilator and run it.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module core_tb -Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== sources.f ====
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/fetch_decode.sv
logic/idex_reg.sv
logic/execute_stage.sv
logic/rv_core.sv
verification/core_tb.sv

// ==== verification/core_tb.sv ====
// core testbench: random program, instruction memory model,
// reference instruction-set model and retire checker.

`timescale 1ns/1ps
`include "core_params.svh"

module core_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int NUM_RAND = 200;
    localparam int PROG_LEN = NUM_RAND + 1;
    localparam int LIMIT    = NUM_RAND * (`CORE_MUL_CYCLES + 2) + 100;

    typedef enum int {
        K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR,
        K_SLT, K_LUI, K_MUL, K_BEQ, K_BNE, K_JAL
    } kind_e;

    logic    clk;
    logic    reset;
    pc_t     imem_addr;
    inst_t   imem_data;
    retire_t retire;

    kind_e p_kind [PROG_LEN];
    int    p_rd   [PROG_LEN];
    int    p_rs1  [PROG_LEN];
    int    p_rs2  [PROG_LEN];
    xlen_t p_imm  [PROG_LEN];
    inst_t p_word [PROG_LEN];

    xlen_t m_regs [32];
    pc_t   m_pc;
    int    hits [7];
    int    errs [7];
    int    prev_rd;
    logic  prev_mul;
    logic  prev_branch;
    logic  prev_taken;
    pc_t   skip_pc;
    logic  first_seen;
    int    final_hits;
    pc_t   final_pc;

    rv_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // outside the program an illegal opcode comes back.
    function automatic inst_t fetch_word(pc_t addr);
        logic [31:0] fold;
        fold = addr[31:0] ^ addr[63:32];
        if (addr[1:0] == 2'b00 && addr < pc_t'(PROG_LEN * 4)) begin
            return p_word[int'(addr[31:2])];
        end
        return {fold[31:7] ^ 25'(fold[6:0]), 7'b0000000};
    endfunction

    assign imem_data = fetch_word(imem_addr);

    function automatic inst_t encode(int i);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        xlen_t      imm;
        rd  = 5'(p_rd[i]);
        rs1 = 5'(p_rs1[i]);
        rs2 = 5'(p_rs2[i]);
        imm = p_imm[i];
        case (p_kind[i])
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_MUL:  return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_LUI:  return {imm[31:12], rd, 7'b0110111};
            K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
        endcase
    endfunction

    // forward jumps only, skipping 1 to 4 instructions, never past the final loop.
    task automatic build_program();
        int          k;
        logic [11:0] imm12;
        logic [19:0] imm20;
        for (int i = 0; i < NUM_RAND; i++) begin
            p_kind[i] = kind_e'(int'($urandom % 12));
            p_rd[i]   = int'($urandom % 8);
            p_rs1[i]  = int'($urandom % 8);
            p_rs2[i]  = int'($urandom % 8);
            imm12     = 12'($urandom);
            imm20     = 20'($urandom);
            k         = 1 + int'($urandom % 4);
            if (i + k + 1 > NUM_RAND) begin
                k = NUM_RAND - i - 1;
            end
            p_imm[i] = '0;
            if (p_kind[i] == K_ADDI) begin
                p_imm[i] = {{52{imm12[11]}}, imm12};
            end else if (p_kind[i] == K_LUI) begin
                p_imm[i] = {{32{imm20[19]}}, imm20, 12'b0};
            end else if (p_kind[i] inside {K_BEQ, K_BNE, K_JAL}) begin
                if (k < 1) begin
                    p_kind[i] = K_ADD;
                end else begin
                    p_imm[i] = xlen_t'((k + 1) * 4);
                end
            end
        end
        p_kind[NUM_RAND] = K_JAL;
        p_rd[NUM_RAND]   = 0;
        p_rs1[NUM_RAND]  = 0;
        p_rs2[NUM_RAND]  = 0;
        p_imm[NUM_RAND]  = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            p_word[i] = encode(i);
        end
    endtask

    // one architectural step of the instruction at m_pc.
    task automatic model_step(output pc_t pc, output logic rd_ena, output int rd,
                              output xlen_t value, output logic taken, output int idx);
        xlen_t a;
        xlen_t b;
        xlen_t res;
        idx    = int'(m_pc >> 2);
        pc     = m_pc;
        a      = m_regs[p_rs1[idx]];
        b      = m_regs[p_rs2[idx]];
        rd     = p_rd[idx];
        rd_ena = !(p_kind[idx] inside {K_BEQ, K_BNE});
        taken  = 1'b0;
        res    = '0;
        case (p_kind[idx])
            K_ADDI: res = a + p_imm[idx];
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            K_LUI:  res = p_imm[idx];
            K_MUL:  res = a * b;
            K_BEQ:  taken = (a == b);
            K_BNE:  taken = (a != b);
            default: begin
                res   = m_pc + 64'd4;
                taken = 1'b1;
            end
        endcase
        value = (rd == 0) ? '0 : res;
        if (rd_ena && rd != 0) begin
            m_regs[rd] = res;
        end
        m_pc = taken ? m_pc + p_imm[idx] : m_pc + 64'd4;
    endtask

    task automatic check_value(input int beh, input string name,
                               input xlen_t actual, input xlen_t expected);
        hits[beh] = hits[beh] + 1;
        if (actual !== expected) begin
            errs[beh] = errs[beh] + 1;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic string beh_name(int b);
        case (b)
            1: return "retire matches model";
            2: return "x0 writes and reads";
            3: return "bypassed dependent operands";
            4: return "mul result and order";
            5: return "branch and jal control flow";
            default: return "reset and first retire";
        endcase
    endfunction

    task automatic handle_retire();
        pc_t   e_pc;
        logic  e_ena;
        int    e_rd;
        xlen_t e_val;
        logic  e_taken;
        int    idx;
        int    val_beh;
        logic  use1;
        logic  use2;
        logic  reads_x0;
        logic  dependent;
        model_step(e_pc, e_ena, e_rd, e_val, e_taken, idx);
        if (!first_seen) begin
            check_value(6, "retire.pc", retire.pc, `CORE_RESET_PC);
        end
        if (prev_taken) begin
            check_value(5, "retire.pc is squashed", xlen_t'(retire.pc == skip_pc), '0);
        end
        check_value(prev_mul ? 4 : (prev_branch ? 5 : 1), "retire.pc", retire.pc, e_pc);
        check_value(1, "retire.rd_ena", xlen_t'(retire.rd_ena), xlen_t'(e_ena));
        if (e_ena) begin
            use1      = !(p_kind[idx] inside {K_LUI, K_JAL});
            use2      = !(p_kind[idx] inside {K_ADDI, K_LUI, K_JAL});
            reads_x0  = (use1 && p_rs1[idx] == 0) || (use2 && p_rs2[idx] == 0);
            dependent = prev_rd > 0 && ((use1 && p_rs1[idx] == prev_rd) ||
                                        (use2 && p_rs2[idx] == prev_rd));
            val_beh   = (e_rd == 0 || reads_x0) ? 2 :
                        (p_kind[idx] == K_MUL) ? 4 : (dependent ? 3 : 1);
            check_value(val_beh, "retire.rd_addr", xlen_t'(retire.rd_addr), xlen_t'(e_rd));
            check_value(val_beh, "retire.value", retire.value, e_val);
        end
        prev_rd     = e_ena ? e_rd : -1;
        prev_mul    = (p_kind[idx] == K_MUL);
        prev_branch = (p_kind[idx] inside {K_BEQ, K_BNE, K_JAL});
        prev_taken  = e_taken;
        skip_pc     = e_pc + 64'd4;
        first_seen  = 1'b1;
        if (e_pc == final_pc) begin
            final_hits = final_hits + 1;
        end
    endtask

    initial begin
        int   cycles;
        logic timed_out;
        logic missing;
        int   total_hits;
        int   total_errs;
        reset       = 1'b1;
        cycles      = 0;
        timed_out   = 1'b0;
        missing     = 1'b0;
        total_hits  = 0;
        total_errs  = 0;
        m_pc        = `CORE_RESET_PC;
        prev_rd     = -1;
        prev_mul    = 1'b0;
        prev_branch = 1'b0;
        prev_taken  = 1'b0;
        skip_pc     = '0;
        first_seen  = 1'b0;
        final_hits  = 0;
        final_pc    = pc_t'(NUM_RAND * 4);
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        void'($urandom(32'h196a));
        build_program();

        for (int i = 0; i < 15; i++) begin
            @(negedge clk);
            check_value(6, "retire.valid", xlen_t'(retire.valid), '0);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(6, "imem_addr", imem_addr, `CORE_RESET_PC);

        // sample at the falling edge, where all outputs have settled.
        while (final_hits < 2 && !timed_out) begin
            if (retire.valid) begin
                handle_retire();
            end
            cycles = cycles + 1;
            if (final_hits < 2) begin
                if (cycles >= LIMIT) begin
                    timed_out = 1'b1;
                    $display("Timeout: final loop did not retire twice in %0d cycles", LIMIT);
                end else begin
                    @(negedge clk);
                end
            end
        end

        for (int b = 1; b <= 6; b++) begin
            $display("%s: %0d checks, %0d errors", beh_name(b), hits[b], errs[b]);
            if (hits[b] == 0) begin
                missing = 1'b1;
                $display("%s was never exercised by the program", beh_name(b));
            end
            total_hits = total_hits + hits[b];
            total_errs = total_errs + errs[b];
        end
        $display("summary: %0d checks, %0d errors", total_hits, total_errs);
        if (total_errs == 0 && !timed_out && !missing) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
